// ==== cpu.sv ====
`timescale 1ns/1ps

module cpu (
   input  logic                           clk,
   input  logic                           rst_n,
   input  logic                           run,
   input  logic                           load_en,
   input  logic [cpu_pkg::MEM_ADDR_W-1:0] load_addr,
   input  logic [cpu_pkg::DATA_W-1:0]     load_data,
   output logic                           retire_valid,
   output cpu_pkg::retire_t               retire,
   output logic                           store_valid,
   output cpu_pkg::store_t                store,
   output logic                           halted
);

   cpu_pkg::stage_e                stage;
   logic [cpu_pkg::MEM_ADDR_W-1:0] pc;
   logic [cpu_pkg::DATA_W-1:0]     instr;
   cpu_pkg::decoded_t              dec;
   logic [cpu_pkg::DATA_W-1:0]     ra_data;
   logic [cpu_pkg::DATA_W-1:0]     rb_data;
   logic [cpu_pkg::DATA_W-1:0]     rdata;
   logic [cpu_pkg::DATA_W-1:0]     alu_result;
   logic                           rf_wr_en;
   logic [cpu_pkg::DATA_W-1:0]     rf_wr_data;

   cpu_control control_i (
      .clk(clk), .rst_n(rst_n), .run(run), .dec(dec),
      .ra_data(ra_data), .rb_data(rb_data), .rdata(rdata),
      .stage(stage), .pc(pc), .instr(instr), .halted(halted)
   );

   cpu_decoder decoder_i (.instr(instr), .dec(dec));

   cpu_regfile regfile_i (
      .clk(clk), .rst_n(rst_n), .stage(stage), .dec(dec),
      .rdata(rdata), .alu_result(alu_result),
      .ra_data(ra_data), .rb_data(rb_data),
      .wr_en(rf_wr_en), .wr_data(rf_wr_data)
   );

   cpu_alu alu_i (.a(ra_data), .b(rb_data), .op(dec.alu_op), .result(alu_result));

   cpu_memory memory_i (
      .clk(clk), .stage(stage), .pc(pc), .dec(dec),
      .ra_data(ra_data), .rb_data(rb_data), .run(run),
      .load_en(load_en), .load_addr(load_addr), .load_data(load_data),
      .rdata(rdata), .store_valid(store_valid), .store(store)
   );

   // One retirement per instruction, in WRITEBACK
   assign retire_valid   = run && (stage == cpu_pkg::ST_WRITEBACK);
   assign retire.pc      = pc;
   assign retire.op      = dec.op;
   assign retire.wr_en   = rf_wr_en;
   assign retire.wr_reg  = dec.rd;
   assign retire.wr_data = rf_wr_data;

endmodule

// ==== cpu_alu.sv ====
`timescale 1ns/1ps

module cpu_alu (
   input  logic [cpu_pkg::DATA_W-1:0] a,
   input  logic [cpu_pkg::DATA_W-1:0] b,
   input  cpu_pkg::alu_op_e           op,
   output logic [cpu_pkg::DATA_W-1:0] result
);

   logic [4:0] shamt;

   assign shamt = b[4:0];

   always_comb begin
      case (op)
         cpu_pkg::ALU_ADD:  result = a + b;
         cpu_pkg::ALU_SUB:  result = a - b;
         cpu_pkg::ALU_AND:  result = a & b;
         cpu_pkg::ALU_OR:   result = a | b;
         cpu_pkg::ALU_XOR:  result = a ^ b;
         // Unsigned compare gives 1 or 0
         cpu_pkg::ALU_SLTU: result = {{(cpu_pkg::DATA_W - 1){1'b0}}, (a < b)};
         cpu_pkg::ALU_SHL:  result = a << shamt;
         cpu_pkg::ALU_SHR:  result = a >> shamt;
         default:           result = '0;
      endcase
   end

endmodule

// ==== cpu_control.sv ====
`timescale 1ns/1ps

module cpu_control (
   input  logic                               clk,
   input  logic                               rst_n,
   input  logic                               run,
   input  cpu_pkg::decoded_t                  dec,
   input  logic [cpu_pkg::DATA_W-1:0]         ra_data,
   input  logic [cpu_pkg::DATA_W-1:0]         rb_data,
   input  logic [cpu_pkg::DATA_W-1:0]         rdata,
   output cpu_pkg::stage_e                    stage,
   output logic [cpu_pkg::MEM_ADDR_W-1:0]     pc,
   output logic [cpu_pkg::DATA_W-1:0]         instr,
   output logic                               halted
);

   logic                               step;
   logic                               last_stage;
   logic                               issue_load;
   logic                               wb_step;
   logic                               take_jump;
   logic [cpu_pkg::MEM_ADDR_W-1:0]     pc_next;
   cpu_pkg::stage_e                    stage_next;

   // Nothing moves while stopped or halted
   assign step       = run && !halted;
   assign last_stage = (stage == cpu_pkg::stage_e'(cpu_pkg::NUM_STAGES - 1));
   assign issue_load = step && (stage == cpu_pkg::ST_ISSUE);
   assign wb_step    = step && last_stage;

   always_comb begin
      if (last_stage) begin
         stage_next = cpu_pkg::ST_FETCH;
      end else begin
         stage_next = cpu_pkg::stage_e'(stage + 3'd1);
      end
   end

   // Jump target comes from the second register operand
   assign take_jump = (dec.op == cpu_pkg::OP_JUMPNZ) && (ra_data != '0);

   always_comb begin
      if (take_jump) begin
         pc_next = rb_data[cpu_pkg::MEM_ADDR_W-1:0];
      end else begin
         // Wraps at the top of memory
         pc_next = pc + cpu_pkg::MEM_ADDR_W'(1);
      end
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         stage <= cpu_pkg::ST_FETCH;
      end else if (step) begin
         stage <= stage_next;
      end
   end

   // Issue register
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         instr <= '0;
      end else if (issue_load) begin
         instr <= rdata;
      end
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         pc     <= '0;
         halted <= 1'b0;
      end else if (wb_step) begin
         pc <= pc_next;
         if (dec.op == cpu_pkg::OP_HALT) begin
            halted <= 1'b1;
         end
      end
   end

endmodule

// ==== cpu_decoder.sv ====
`timescale 1ns/1ps

module cpu_decoder (
   input  logic [cpu_pkg::DATA_W-1:0] instr,
   output cpu_pkg::decoded_t          dec
);

   cpu_pkg::instr_u  word;
   cpu_pkg::opcode_e op;

   assign word = instr;

   // Unknown encodings behave as NOP
   always_comb begin
      case (word.reg_view.opcode)
         cpu_pkg::OP_LOADI,
         cpu_pkg::OP_LOAD,
         cpu_pkg::OP_STORE,
         cpu_pkg::OP_ALU,
         cpu_pkg::OP_JUMPNZ,
         cpu_pkg::OP_HALT: op = cpu_pkg::opcode_e'(word.reg_view.opcode);
         default:          op = cpu_pkg::OP_NOP;
      endcase
   end

   always_comb begin
      dec.op     = op;
      dec.rd     = word.reg_view.rd;
      dec.ra     = word.reg_view.ra;
      dec.rb     = word.reg_view.rb;
      dec.alu_op = cpu_pkg::alu_op_e'(word.reg_view.alu_op);
      dec.imm    = {{(cpu_pkg::DATA_W - 16){1'b0}}, word.imm_view.imm16};
   end

endmodule

// ==== cpu_memory.sv ====
`timescale 1ns/1ps

module cpu_memory (
   input  logic                           clk,
   input  cpu_pkg::stage_e                stage,
   input  logic [cpu_pkg::MEM_ADDR_W-1:0] pc,
   input  cpu_pkg::decoded_t              dec,
   input  logic [cpu_pkg::DATA_W-1:0]     ra_data,
   input  logic [cpu_pkg::DATA_W-1:0]     rb_data,
   input  logic                           run,
   input  logic                           load_en,
   input  logic [cpu_pkg::MEM_ADDR_W-1:0] load_addr,
   input  logic [cpu_pkg::DATA_W-1:0]     load_data,
   output logic [cpu_pkg::DATA_W-1:0]     rdata,
   output logic                           store_valid,
   output cpu_pkg::store_t                store
);

   logic [cpu_pkg::DATA_W-1:0]     mem [cpu_pkg::MEM_DEPTH];
   logic                           rd_en;
   logic [cpu_pkg::MEM_ADDR_W-1:0] rd_addr;
   logic                           wr_en;
   logic [cpu_pkg::MEM_ADDR_W-1:0] wr_addr;
   logic [cpu_pkg::DATA_W-1:0]     wr_data;

   // Instruction fetch in FETCH, load data in EXECUTE
   assign rd_en   = (stage == cpu_pkg::ST_FETCH) ||
                    ((stage == cpu_pkg::ST_EXECUTE) && (dec.op == cpu_pkg::OP_LOAD));
   assign rd_addr = (stage == cpu_pkg::ST_FETCH) ? pc : ra_data[cpu_pkg::MEM_ADDR_W-1:0];

   // STORE writes ra value at the rb address
   assign store_valid = run && (stage == cpu_pkg::ST_EXECUTE) &&
                        (dec.op == cpu_pkg::OP_STORE);
   assign store.addr  = rb_data[cpu_pkg::MEM_ADDR_W-1:0];
   assign store.data  = ra_data;

   // Program loading only while stopped
   assign wr_en   = (!run && load_en) || store_valid;
   assign wr_addr = run ? store.addr : load_addr;
   assign wr_data = run ? store.data : load_data;

   always_ff @(posedge clk) begin
      if (wr_en) begin
         mem[wr_addr] <= wr_data;
      end
      if (rd_en) begin
         rdata <= mem[rd_addr];
      end
   end

endmodule

// ==== cpu_pkg.sv ====
package cpu_pkg;

   localparam int DATA_W     = 32;
   localparam int REG_COUNT  = 32;
   localparam int REG_ADDR_W = 5;
   localparam int MEM_DEPTH  = 256;
   localparam int MEM_ADDR_W = 8;
   localparam int NUM_STAGES = 5;

   // Instruction type in bits 31..27
   typedef enum logic [4:0] {
      OP_NOP    = 5'd0,
      OP_LOADI  = 5'd1,
      OP_LOAD   = 5'd2,
      OP_STORE  = 5'd3,
      OP_ALU    = 5'd4,
      OP_JUMPNZ = 5'd5,
      OP_HALT   = 5'd6
   } opcode_e;

   typedef enum logic [2:0] {
      ALU_ADD  = 3'd0,
      ALU_SUB  = 3'd1,
      ALU_AND  = 3'd2,
      ALU_OR   = 3'd3,
      ALU_XOR  = 3'd4,
      ALU_SLTU = 3'd5,
      ALU_SHL  = 3'd6,
      ALU_SHR  = 3'd7
   } alu_op_e;

   typedef enum logic [2:0] {
      ST_FETCH     = 3'd0,
      ST_ISSUE     = 3'd1,
      ST_READ      = 3'd2,
      ST_EXECUTE   = 3'd3,
      ST_WRITEBACK = 3'd4
   } stage_e;

   // LOADI view
   typedef struct packed {
      logic [4:0]            opcode;
      logic [REG_ADDR_W-1:0] rd;
      logic [5:0]            unused;
      logic [15:0]           imm16;
   } instr_imm_t;

   // View for all register based types
   typedef struct packed {
      logic [4:0]            opcode;
      logic [REG_ADDR_W-1:0] rd;
      logic [REG_ADDR_W-1:0] ra;
      logic [REG_ADDR_W-1:0] rb;
      logic [2:0]            alu_op;
      logic [8:0]            unused;
   } instr_reg_t;

   typedef union packed {
      instr_imm_t imm_view;
      instr_reg_t reg_view;
   } instr_u;

   typedef struct packed {
      opcode_e               op;
      logic [REG_ADDR_W-1:0] rd;
      logic [REG_ADDR_W-1:0] ra;
      logic [REG_ADDR_W-1:0] rb;
      logic [DATA_W-1:0]     imm;
      alu_op_e               alu_op;
   } decoded_t;

   typedef struct packed {
      logic [MEM_ADDR_W-1:0] pc;
      opcode_e               op;
      logic                  wr_en;
      logic [REG_ADDR_W-1:0] wr_reg;
      logic [DATA_W-1:0]     wr_data;
   } retire_t;

   typedef struct packed {
      logic [MEM_ADDR_W-1:0] addr;
      logic [DATA_W-1:0]     data;
   } store_t;

endpackage

// ==== cpu_properties.sv ====
`timescale 1ns/1ps

module cpu_properties (
   input logic                           clk,
   input logic                           rst_n,
   input logic                           run,
   input logic                           halted,
   input cpu_pkg::stage_e                stage,
   input logic [cpu_pkg::MEM_ADDR_W-1:0] pc,
   input logic                           store_valid,
   input logic                           retire_valid
);

   logic step;

   assign step = run && !halted;

   // Stage order FETCH to WRITEBACK, then back to FETCH
   a_stage_step: assert property (@(posedge clk) disable iff (!rst_n)
      (step && stage != cpu_pkg::ST_WRITEBACK) |=>
         (stage == cpu_pkg::stage_e'($past(stage) + 3'd1)))
      else $error("stage did not advance by one");

   a_stage_wrap: assert property (@(posedge clk) disable iff (!rst_n)
      (step && stage == cpu_pkg::ST_WRITEBACK) |=> (stage == cpu_pkg::ST_FETCH))
      else $error("stage did not return to FETCH");

   a_stage_hold: assert property (@(posedge clk) disable iff (!rst_n)
      !step |=> $stable(stage))
      else $error("stage moved while stopped or halted");

   // A store is followed directly by its writeback
   a_store_stage: assert property (@(posedge clk) disable iff (!rst_n)
      store_valid |=> (stage == cpu_pkg::ST_WRITEBACK))
      else $error("store not followed by WRITEBACK");

   // One retirement per pass through the stages
   a_retire_stage: assert property (@(posedge clk) disable iff (!rst_n)
      retire_valid |=> !retire_valid [*4])
      else $error("retirement repeated within one instruction");

   // PC only moves as WRITEBACK ends
   a_pc_hold: assert property (@(posedge clk) disable iff (!rst_n)
      !(step && stage == cpu_pkg::ST_WRITEBACK) |=> $stable(pc))
      else $error("pc changed outside WRITEBACK");

endmodule

bind cpu cpu_properties cpu_properties_i (
   .clk(clk), .rst_n(rst_n), .run(run), .halted(halted), .stage(stage),
   .pc(pc), .store_valid(store_valid), .retire_valid(retire_valid)
);

// ==== cpu_regfile.sv ====
`timescale 1ns/1ps

module cpu_regfile (
   input  logic                       clk,
   input  logic                       rst_n,
   input  cpu_pkg::stage_e            stage,
   input  cpu_pkg::decoded_t          dec,
   input  logic [cpu_pkg::DATA_W-1:0] rdata,
   input  logic [cpu_pkg::DATA_W-1:0] alu_result,
   output logic [cpu_pkg::DATA_W-1:0] ra_data,
   output logic [cpu_pkg::DATA_W-1:0] rb_data,
   output logic                       wr_en,
   output logic [cpu_pkg::DATA_W-1:0] wr_data
);

   logic [cpu_pkg::DATA_W-1:0] regs [cpu_pkg::REG_COUNT];
   logic                       writes_rd;

   // Write data by instruction type
   always_comb begin
      writes_rd = 1'b1;
      case (dec.op)
         cpu_pkg::OP_LOADI: wr_data = dec.imm;
         cpu_pkg::OP_LOAD:  wr_data = rdata;
         cpu_pkg::OP_ALU:   wr_data = alu_result;
         default: begin
            writes_rd = 1'b0;
            wr_data   = '0;
         end
      endcase
   end

   assign wr_en = writes_rd && (stage == cpu_pkg::ST_WRITEBACK);

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         for (int i = 0; i < cpu_pkg::REG_COUNT; i++) begin
            regs[i] <= '0;
         end
      end else if (wr_en) begin
         regs[dec.rd] <= wr_data;
      end
   end

   // Operands sampled once at the end of READ
   always_ff @(posedge clk) begin
      if (stage == cpu_pkg::ST_READ) begin
         ra_data <= regs[dec.ra];
         rb_data <= regs[dec.rb];
      end
   end

endmodule

// ==== tb_cpu.sv ====
`timescale 1ns/1ps

module tb_cpu;

   // Instruction count of all programs, rounded up
   localparam int INSTR_TOTAL = 80;
   localparam int LOAD_WORDS  = 70;
   localparam int IDLE_CYCLES = 8 * 40;
   localparam int CYCLE_LIMIT = 5 * INSTR_TOTAL * 2 + LOAD_WORDS + IDLE_CYCLES;

   logic              clk;
   logic              rst_n;
   logic              run;
   logic              load_en;
   logic [7:0]        load_addr;
   logic [31:0]       load_data;
   logic              retire_valid;
   cpu_pkg::retire_t  retire;
   logic              store_valid;
   cpu_pkg::store_t   store;
   logic              halted;

   logic [31:0] lfsr = 32'h0fb350a8;
   int          cycle_count;
   int          retire_total;
   logic [31:0] prog [$];

   // Reference model state and its prediction for the current instruction
   logic [31:0] mregs [32];
   logic [31:0] mmem [256];
   logic [7:0]  mpc;
   logic [7:0]  exp_pc;
   logic [4:0]  exp_op;
   logic        exp_wr_en;
   logic [4:0]  exp_wr_reg;
   logic [31:0] exp_wr_data;
   logic        exp_st_valid;
   logic [7:0]  exp_st_addr;
   logic [31:0] exp_st_data;
   logic        exp_halt;

   cpu cpu_i (
      .clk(clk), .rst_n(rst_n), .run(run), .load_en(load_en),
      .load_addr(load_addr), .load_data(load_data),
      .retire_valid(retire_valid), .retire(retire),
      .store_valid(store_valid), .store(store), .halted(halted)
   );

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   initial begin
      cycle_count = 0;
      while (cycle_count < CYCLE_LIMIT) begin
         @(posedge clk);
         cycle_count++;
      end
      $display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
      $display("=== FAIL ===");
      $fatal(1, "Timeout");
   end

   task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
      if (got !== exp) begin
         $display("** Error %s: got 0x%0h, expected 0x%0h", name, got, exp);
         $display("=== FAIL ===");
         $fatal(1, "Mismatch on %s", name);
      end
   endtask

   // Fibonacci LFSR, taps 32 22 2 1
   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] val;
      logic        fb;
      val = '0;
      for (int i = 0; i < n; i++) begin
         fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
         lfsr = {lfsr[30:0], fb};
         val  = {val[30:0], fb};
      end
      return val;
   endfunction

   function automatic logic [31:0] loadi(input logic [4:0] rd, input logic [15:0] imm);
      return {cpu_pkg::OP_LOADI, rd, 6'd0, imm};
   endfunction

   function automatic logic [31:0] reg_instr(input cpu_pkg::opcode_e op,
         input logic [4:0] rd, input logic [4:0] ra, input logic [4:0] rb,
         input logic [2:0] alu_op);
      return {op, rd, ra, rb, alu_op, 9'd0};
   endfunction

   function automatic logic [31:0] alu_ref(input logic [2:0] op, input logic [31:0] a,
         input logic [31:0] b);
      case (op)
         3'd0:    return a + b;
         3'd1:    return a - b;
         3'd2:    return a & b;
         3'd3:    return a | b;
         3'd4:    return a ^ b;
         3'd5:    return (a < b) ? 32'd1 : 32'd0;
         3'd6:    return a << b[4:0];
         default: return a >> b[4:0];
      endcase
   endfunction

   task automatic reset_dut();
      @(negedge clk);
      rst_n = 1'b0;
      run   = 1'b0;
      repeat (5) @(posedge clk);
      @(negedge clk);
      rst_n = 1'b1;
      for (int i = 0; i < 32; i++) begin
         mregs[i] = '0;
      end
      mpc = '0;
   endtask

   // Writes the queued program from address 0 while run is low
   task automatic load_program();
      reset_dut();
      foreach (prog[i]) begin
         load_en   = 1'b1;
         load_addr = 8'(i);
         load_data = prog[i];
         mmem[i]   = prog[i];
         @(negedge clk);
      end
      load_en = 1'b0;
      prog.delete();
   endtask

   // Executes one instruction in the model
   task automatic predict_next();
      logic [31:0] word;
      logic [31:0] a;
      logic [31:0] b;
      word         = mmem[mpc];
      a            = mregs[word[21:17]];
      b            = mregs[word[16:12]];
      exp_pc       = mpc;
      exp_op       = (word[31:27] <= 5'd6) ? word[31:27] : 5'd0;
      exp_wr_reg   = word[26:22];
      exp_wr_en    = 1'b0;
      exp_wr_data  = '0;
      exp_st_valid = 1'b0;
      exp_halt     = 1'b0;
      mpc          = mpc + 8'd1;
      case (exp_op)
         cpu_pkg::OP_LOADI: begin
            exp_wr_en   = 1'b1;
            exp_wr_data = {16'd0, word[15:0]};
         end
         cpu_pkg::OP_LOAD: begin
            exp_wr_en   = 1'b1;
            exp_wr_data = mmem[a[7:0]];
         end
         cpu_pkg::OP_STORE: begin
            exp_st_valid    = 1'b1;
            exp_st_addr     = b[7:0];
            exp_st_data     = a;
            mmem[b[7:0]]    = a;
         end
         cpu_pkg::OP_ALU: begin
            exp_wr_en   = 1'b1;
            exp_wr_data = alu_ref(word[11:9], a, b);
         end
         cpu_pkg::OP_JUMPNZ: begin
            if (a != '0) begin
               mpc = b[7:0];
            end
         end
         cpu_pkg::OP_HALT: exp_halt = 1'b1;
         default: ;
      endcase
      if (exp_wr_en) begin
         mregs[exp_wr_reg] = exp_wr_data;
      end
   endtask

   // Runs the loaded program to its HALT and checks every pulse
   task automatic execute_program();
      int   cyc;
      int   last_ret;
      logic store_seen;
      logic done;
      cyc          = 0;
      last_ret     = -1;
      store_seen   = 1'b0;
      done         = 1'b0;
      retire_total = 0;
      predict_next();
      run = 1'b1;
      while (!done) begin
         @(negedge clk);
         cyc++;
         if (store_valid) begin
            check("store_valid", store_valid, exp_st_valid);
            check("store.addr", store.addr, exp_st_addr);
            check("store.data", store.data, exp_st_data);
            store_seen = 1'b1;
         end
         if (retire_valid) begin
            check("retire spacing", cyc - last_ret, 5);
            check("retire.pc", retire.pc, exp_pc);
            check("retire.op", retire.op, exp_op);
            check("retire.wr_en", retire.wr_en, exp_wr_en);
            check("retire.wr_reg", retire.wr_reg, exp_wr_reg);
            check("retire.wr_data", retire.wr_data, exp_wr_data);
            check("store pulse", store_seen, exp_st_valid);
            check("halted", halted, 1'b0);
            last_ret   = cyc;
            store_seen = 1'b0;
            retire_total++;
            if (exp_halt) begin
               done = 1'b1;
            end else begin
               predict_next();
            end
         end
      end
      @(negedge clk);
      check("halted", halted, 1'b1);
      repeat (20) begin
         @(negedge clk);
         check("retire_valid", retire_valid, 1'b0);
         check("store_valid", store_valid, 1'b0);
      end
      run = 1'b0;
   endtask

   task automatic idle_after_reset();
      reset_dut();
      check("retire_valid", retire_valid, 1'b0);
      check("store_valid", store_valid, 1'b0);
      check("halted", halted, 1'b0);
      repeat (20) begin
         @(negedge clk);
         check("retire_valid", retire_valid, 1'b0);
         check("store_valid", store_valid, 1'b0);
      end
   endtask

   task automatic random_loadi();
      repeat (6) prog.push_back(loadi(5'(rand_bits(5)), 16'(rand_bits(16))));
      prog.push_back(reg_instr(cpu_pkg::OP_HALT, 0, 0, 0, 0));
      load_program();
      execute_program();
   endtask

   task automatic all_alu_ops();
      prog.push_back(loadi(1, 16'(rand_bits(16))));
      prog.push_back(loadi(2, 16'(rand_bits(16))));
      prog.push_back(loadi(3, 16));
      // Build two full-width operands
      prog.push_back(reg_instr(cpu_pkg::OP_ALU, 4, 1, 3, cpu_pkg::ALU_SHL));
      prog.push_back(reg_instr(cpu_pkg::OP_ALU, 4, 4, 2, cpu_pkg::ALU_OR));
      prog.push_back(loadi(5, 16'(rand_bits(16))));
      prog.push_back(reg_instr(cpu_pkg::OP_ALU, 6, 5, 3, cpu_pkg::ALU_SHL));
      prog.push_back(reg_instr(cpu_pkg::OP_ALU, 6, 6, 1, cpu_pkg::ALU_XOR));
      for (int op = 0; op < 8; op++) begin
         prog.push_back(reg_instr(cpu_pkg::OP_ALU, 5'(8 + op), 4, 6, 3'(op)));
         prog.push_back(reg_instr(cpu_pkg::OP_ALU, 5'(16 + op), 6, 4, 3'(op)));
      end
      prog.push_back(reg_instr(cpu_pkg::OP_HALT, 0, 0, 0, 0));
      load_program();
      execute_program();
   endtask

   task automatic store_then_load();
      prog.push_back(loadi(1, 16'(rand_bits(16))));
      prog.push_back(loadi(2, 16'h0080 + 16'(rand_bits(4))));
      prog.push_back(reg_instr(cpu_pkg::OP_STORE, 0, 1, 2, 0));
      prog.push_back(loadi(3, 16'(rand_bits(16))));
      prog.push_back(loadi(4, 16'h00a0 + 16'(rand_bits(4))));
      prog.push_back(reg_instr(cpu_pkg::OP_STORE, 0, 3, 4, 0));
      prog.push_back(reg_instr(cpu_pkg::OP_LOAD, 5, 2, 0, 0));
      prog.push_back(reg_instr(cpu_pkg::OP_LOAD, 6, 4, 0, 0));
      prog.push_back(reg_instr(cpu_pkg::OP_HALT, 0, 0, 0, 0));
      load_program();
      execute_program();
   endtask

   task automatic jump_fall_and_take();
      prog.push_back(loadi(5, 0));
      prog.push_back(loadi(6, 6));
      prog.push_back(reg_instr(cpu_pkg::OP_JUMPNZ, 0, 5, 6, 0));
      prog.push_back(loadi(7, 16'(rand_bits(16)) | 16'h0001));
      prog.push_back(reg_instr(cpu_pkg::OP_JUMPNZ, 0, 7, 6, 0));
      prog.push_back(loadi(8, 16'hdead));
      prog.push_back(reg_instr(cpu_pkg::OP_HALT, 0, 0, 0, 0));
      load_program();
      execute_program();
      check("retired instructions", retire_total, 6);
   endtask

   task automatic counted_loop();
      int n;
      n = 2 + int'(rand_bits(2));
      prog.push_back(loadi(1, 16'(n)));
      prog.push_back(loadi(2, 1));
      prog.push_back(loadi(3, 4));
      prog.push_back(loadi(4, 0));
      prog.push_back(reg_instr(cpu_pkg::OP_ALU, 4, 4, 2, cpu_pkg::ALU_ADD));
      prog.push_back(reg_instr(cpu_pkg::OP_ALU, 1, 1, 2, cpu_pkg::ALU_SUB));
      prog.push_back(reg_instr(cpu_pkg::OP_JUMPNZ, 0, 1, 3, 0));
      prog.push_back(reg_instr(cpu_pkg::OP_HALT, 0, 0, 0, 0));
      load_program();
      execute_program();
      // Four setup words, three per pass, then HALT
      check("retired instructions", retire_total, 4 + 3 * n + 1);
   endtask

   task automatic halt_after_unknown();
      prog.push_back({5'd20, 27'(rand_bits(27))});
      prog.push_back(reg_instr(cpu_pkg::OP_HALT, 0, 0, 0, 0));
      load_program();
      execute_program();
      check("retired instructions", retire_total, 2);
   endtask

   initial begin
      rst_n     = 1'b0;
      run       = 1'b0;
      load_en   = 1'b0;
      load_addr = '0;
      load_data = '0;
      idle_after_reset();
      random_loadi();
      all_alu_ops();
      store_then_load();
      jump_fall_and_take();
      counted_loop();
      halt_after_unknown();
      $display("=== PASS ===");
      $finish;
   end

endmodule

// ==== vlog.f ====
cpu_pkg.sv
cpu_alu.sv
cpu_decoder.sv
cpu_regfile.sv
cpu_memory.sv
cpu_control.sv
cpu.sv
cpu_properties.sv
tb_cpu.sv
